//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 16;
    localparam int REG_AW     = 3;
    localparam int PROG_AW    = 8;
    localparam int NUM_REGS   = 1 << REG_AW;
    localparam int PROG_DEPTH = 1 << PROG_AW;

    // instruction word, msb first
    typedef struct packed {
        logic [6:0] cop;     // opcode
        logic       d;       // direction, 1 = rg is destination
        logic [1:0] mod;     // address mode, only 11 runs
        logic [2:0] rg;
        logic [2:0] rm;
    } instr_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic sign;
    } flags_t;

    typedef enum logic [3:0] {
        ADC  = 4'd0,
        SBB1 = 4'd1,         // a - b - c
        SBB2 = 4'd2,         // b - a - c
        NOT  = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        SHL  = 4'd7,
        SHR  = 4'd8,
        SAR  = 4'd9
    } alu_op_e;

    // source of the internal bus
    typedef enum logic [1:0] {
        BUS_REGS = 2'd0,
        BUS_ALU  = 2'd1,
        BUS_CP   = 2'd2,
        BUS_RAM  = 2'd3
    } bus_src_e;

    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        FETCH0   = 4'd1,     // cp onto bus, load am
        FETCH1   = 4'd2,     // memory read
        FETCH2   = 4'd3,     // load ri
        DECODE   = 4'd4,
        LOAD_SRC = 4'd5,
        LOAD_DST = 4'd6,
        EXEC     = 4'd7,
        STORE    = 4'd8,
        INC_CP0  = 4'd9,
        INC_CP1  = 4'd10
    } seq_state_e;

endpackage

//--- rtl/cpu_ctrl_if.sv
interface cpu_ctrl_if;
    import cpu_pkg::*;

    bus_src_e          bus_src;
    alu_op_e           alu_op;
    logic              alu_carry_in;
    logic              alu_b_zero;     // alu b input forced to zero
    logic [REG_AW-1:0] regs_addr;      // shared read and write address
    logic              regs_we;
    logic              t1_we;
    logic              t2_we;
    logic              ind_we;         // flags from alu
    logic              cp_we;
    logic              ri_we;
    logic              am_we;
    logic              instr_done;
    instr_t            ri;             // back from datapath
    flags_t            ind;

    modport seq (
        output bus_src, alu_op, alu_carry_in, alu_b_zero, regs_addr,
        output regs_we, t1_we, t2_we, ind_we, cp_we, ri_we, am_we, instr_done,
        input  ri, ind
    );

    modport dp (
        input  bus_src, alu_op, alu_carry_in, alu_b_zero, regs_addr,
        input  regs_we, t1_we, t2_we, ind_we, cp_we, ri_we, am_we, instr_done,
        output ri, ind
    );

endinterface

//--- rtl/cpu_alu.sv
module cpu_alu (
    input  logic [cpu_pkg::DATA_W-1:0] i_a,
    input  logic [cpu_pkg::DATA_W-1:0] i_b,
    input  cpu_pkg::alu_op_e           i_op,
    input  logic                       i_carry,
    output logic [cpu_pkg::DATA_W-1:0] o_result,
    output cpu_pkg::flags_t            o_flags
);
    import cpu_pkg::*;

    logic [DATA_W:0] wide;        // carry or borrow on top
    logic [DATA_W:0] a_ext;
    logic [DATA_W:0] b_ext;
    logic [DATA_W:0] c_ext;

    assign a_ext = {1'b0, i_a};
    assign b_ext = {1'b0, i_b};
    assign c_ext = {{DATA_W{1'b0}}, i_carry};

    always_comb begin
        case (i_op)
            ADC:  wide = a_ext + b_ext + c_ext;
            SBB1: wide = a_ext - b_ext - c_ext;
            SBB2: wide = b_ext - a_ext - c_ext;
            NOT:  wide = {1'b0, ~i_a};
            AND:  wide = {1'b0, i_a & i_b};
            OR:   wide = {1'b0, i_a | i_b};
            XOR:  wide = {1'b0, i_a ^ i_b};
            SHL:  wide = {i_a, 1'b0};                          // msb out to carry
            SHR:  wide = {i_a[0], 1'b0, i_a[DATA_W-1:1]};
            SAR:  wide = {i_a[0], i_a[DATA_W-1], i_a[DATA_W-1:1]};
            default: wide = '0;
        endcase
    end

    assign o_result      = wide[DATA_W-1:0];
    assign o_flags.carry = wide[DATA_W];
    assign o_flags.zero  = (wide[DATA_W-1:0] == '0);
    assign o_flags.sign  = wide[DATA_W-1];

endmodule

//--- rtl/cpu_regfile.sv
module cpu_regfile (
    input  logic                       i_w_clk,
    input  logic                       i_w_reset,
    input  logic [cpu_pkg::REG_AW-1:0] i_addr,
    input  logic                       i_we,
    input  logic [cpu_pkg::DATA_W-1:0] i_wdata,
    output logic [cpu_pkg::DATA_W-1:0] o_rdata
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            regs <= '{default: '0};
        end else if (i_we) begin
            regs[i_addr] <= i_wdata;
        end
    end

    assign o_rdata = regs[i_addr];    // async read, same address as write

    a_addr_known: assert property (@(posedge i_w_clk) disable iff (!i_w_reset)
        i_we |-> !$isunknown(i_addr));

endmodule

//--- rtl/cpu_prog_mem.sv
module cpu_prog_mem (
    input  logic                        i_w_clk,
    input  logic                        i_we,
    input  logic [cpu_pkg::PROG_AW-1:0] i_waddr,
    input  logic [cpu_pkg::DATA_W-1:0]  i_wdata,
    input  logic [cpu_pkg::PROG_AW-1:0] i_raddr,
    output logic [cpu_pkg::DATA_W-1:0]  o_rdata
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] mem [PROG_DEPTH];

    // program load from outside
    always_ff @(posedge i_w_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];    // addressed by am

endmodule

//--- rtl/cpu_sequencer.sv
module cpu_sequencer (
    input  logic      i_w_clk,
    input  logic      i_w_reset,
    input  logic      i_start,
    cpu_ctrl_if.seq   ctrl,
    output logic      o_busy
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        CLS_NOP = 2'd0,
        CLS_ONE = 2'd1,
        CLS_TWO = 2'd2
    } exec_class_e;

    seq_state_e        state;
    seq_state_e        state_next;
    exec_class_e       dec_class;
    exec_class_e       dec_class_next;
    logic              dec_store;
    logic              dec_store_next;
    logic              dec_d;
    logic              dec_d_next;
    logic [REG_AW-1:0] dec_rg;
    logic [REG_AW-1:0] dst_addr;
    logic [REG_AW-1:0] src_addr;
    logic [2:0]        op_sel;

    assign op_sel   = ctrl.ri.cop[2:0];
    assign dst_addr = dec_d ? dec_rg : ctrl.ri.rm;    // d is 0 for one operand
    assign src_addr = dec_d ? ctrl.ri.rm : dec_rg;
    assign o_busy   = (state != IDLE);

    // instruction class from ri with any unknown word as nop
    always_comb begin
        dec_class_next = CLS_NOP;
        dec_store_next = 1'b0;
        dec_d_next     = 1'b0;
        if (ctrl.ri.mod == 2'b11 && op_sel != 3'b111) begin
            if (ctrl.ri.cop[6:3] == 4'b0001) begin
                dec_class_next = CLS_ONE;
                dec_store_next = 1'b1;
            end else if (ctrl.ri.cop[6:4] == 3'b010) begin
                dec_class_next = CLS_TWO;
                dec_store_next = ctrl.ri.cop[3];      // clear gives cmp / test
                dec_d_next     = ctrl.ri.d;
            end
        end
    end

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            state     <= IDLE;
            dec_class <= CLS_NOP;
            dec_store <= 1'b0;
            dec_d     <= 1'b0;
            dec_rg    <= '0;
        end else begin
            state <= state_next;
            if (state == DECODE) begin
                dec_class <= dec_class_next;
                dec_store <= dec_store_next;
                dec_d     <= dec_d_next;
                dec_rg    <= ctrl.ri.rg;
            end
        end
    end

    always_comb begin
        state_next        = state;
        ctrl.bus_src      = BUS_ALU;
        ctrl.alu_op       = OR;
        ctrl.alu_carry_in = 1'b0;
        ctrl.alu_b_zero   = 1'b0;
        ctrl.regs_addr    = '0;
        ctrl.regs_we      = 1'b0;
        ctrl.t1_we        = 1'b0;
        ctrl.t2_we        = 1'b0;
        ctrl.ind_we       = 1'b0;
        ctrl.cp_we        = 1'b0;
        ctrl.ri_we        = 1'b0;
        ctrl.am_we        = 1'b0;
        ctrl.instr_done   = 1'b0;

        case (state)
            IDLE: begin
                if (i_start) state_next = FETCH0;
            end
            FETCH0: begin
                ctrl.bus_src = BUS_CP;
                ctrl.am_we   = 1'b1;
                state_next   = FETCH1;
            end
            FETCH1: state_next = FETCH2;              // ram reads at am
            FETCH2: begin
                ctrl.bus_src = BUS_RAM;
                ctrl.ri_we   = 1'b1;
                state_next   = DECODE;
            end
            DECODE: begin
                case (dec_class_next)
                    CLS_ONE: state_next = LOAD_DST;
                    CLS_TWO: state_next = LOAD_SRC;
                    default: state_next = INC_CP0;
                endcase
            end
            LOAD_SRC: begin
                ctrl.bus_src   = BUS_REGS;
                ctrl.regs_addr = src_addr;
                ctrl.t2_we     = 1'b1;
                state_next     = LOAD_DST;
            end
            LOAD_DST: begin
                ctrl.bus_src   = BUS_REGS;
                ctrl.regs_addr = dst_addr;
                ctrl.t1_we     = 1'b1;
                state_next     = EXEC;
            end
            EXEC: begin
                ctrl.t1_we  = 1'b1;                   // result back into t1
                ctrl.ind_we = 1'b1;
                if (dec_class == CLS_ONE) begin
                    ctrl.alu_b_zero = 1'b1;
                    case (op_sel)
                        3'b000: begin                 // INC
                            ctrl.alu_op       = ADC;
                            ctrl.alu_carry_in = 1'b1;
                        end
                        3'b001: begin                 // DEC
                            ctrl.alu_op       = SBB1;
                            ctrl.alu_carry_in = 1'b1;
                        end
                        3'b010: ctrl.alu_op = SBB2;   // NEG as 0 - a
                        3'b011: ctrl.alu_op = NOT;
                        3'b100: ctrl.alu_op = SHL;
                        3'b101: ctrl.alu_op = SHR;
                        default: ctrl.alu_op = SAR;
                    endcase
                end else begin
                    case (op_sel)
                        3'b000: ctrl.alu_op = ADC;    // ADD
                        3'b001: begin
                            ctrl.alu_op       = ADC;
                            ctrl.alu_carry_in = ctrl.ind.carry;
                        end
                        3'b010: ctrl.alu_op = SBB1;   // SUB / CMP
                        3'b011: begin
                            ctrl.alu_op       = SBB1;
                            ctrl.alu_carry_in = ctrl.ind.carry;
                        end
                        3'b100: ctrl.alu_op = AND;
                        3'b101: ctrl.alu_op = OR;
                        default: ctrl.alu_op = XOR;
                    endcase
                end
                state_next = dec_store ? STORE : INC_CP0;
            end
            STORE: begin
                ctrl.alu_b_zero = 1'b1;               // t1 passes through OR
                ctrl.regs_addr  = dst_addr;
                ctrl.regs_we    = 1'b1;
                state_next      = INC_CP0;
            end
            INC_CP0: begin
                ctrl.bus_src = BUS_CP;
                ctrl.t1_we   = 1'b1;
                state_next   = INC_CP1;
            end
            INC_CP1: begin
                ctrl.alu_op       = ADC;              // t1 + 0 + 1
                ctrl.alu_carry_in = 1'b1;
                ctrl.alu_b_zero   = 1'b1;
                ctrl.cp_we        = 1'b1;
                ctrl.instr_done   = 1'b1;
                state_next        = FETCH0;
            end
            default: state_next = IDLE;
        endcase
    end

    // a register write only follows a storing instruction
    a_store_one_writer: assert property (@(posedge i_w_clk) disable iff (!i_w_reset)
        ctrl.regs_we |-> (dec_store && dec_class != CLS_NOP && !ctrl.t1_we));

endmodule

//--- rtl/cpu_datapath.sv
module cpu_datapath (
    input  logic                        i_w_clk,
    input  logic                        i_w_reset,
    cpu_ctrl_if.dp                      ctrl,
    input  logic                        i_prog_we,
    input  logic [cpu_pkg::PROG_AW-1:0] i_prog_addr,
    input  logic [cpu_pkg::DATA_W-1:0]  i_prog_data,
    output logic                        o_reg_we,
    output logic [cpu_pkg::REG_AW-1:0]  o_reg_addr,
    output logic [cpu_pkg::DATA_W-1:0]  o_reg_data,
    output logic                        o_instr_done,
    output logic [cpu_pkg::DATA_W-1:0]  o_pc,
    output cpu_pkg::flags_t             o_flags
);
    import cpu_pkg::*;

    logic [DATA_W-1:0]  bus;
    logic [DATA_W-1:0]  t1;
    logic [DATA_W-1:0]  t2;
    logic [DATA_W-1:0]  cp;
    logic [PROG_AW-1:0] am;
    instr_t             ri;
    flags_t             ind;
    logic [DATA_W-1:0]  alu_b;
    logic [DATA_W-1:0]  alu_result;
    flags_t             alu_flags;
    logic [DATA_W-1:0]  regs_rdata;
    logic [DATA_W-1:0]  mem_rdata;

    assign alu_b = ctrl.alu_b_zero ? '0 : t2;

    cpu_alu u_alu (
        .i_a      (t1),
        .i_b      (alu_b),
        .i_op     (ctrl.alu_op),
        .i_carry  (ctrl.alu_carry_in),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    cpu_regfile u_regs (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_addr    (ctrl.regs_addr),
        .i_we      (ctrl.regs_we),
        .i_wdata   (bus),
        .o_rdata   (regs_rdata)
    );

    cpu_prog_mem u_mem (
        .i_w_clk (i_w_clk),
        .i_we    (i_prog_we),
        .i_waddr (i_prog_addr),
        .i_wdata (i_prog_data),
        .i_raddr (am),
        .o_rdata (mem_rdata)
    );

    always_comb begin
        case (ctrl.bus_src)
            BUS_REGS: bus = regs_rdata;
            BUS_ALU:  bus = alu_result;
            BUS_CP:   bus = cp;
            default:  bus = mem_rdata;     // BUS_RAM
        endcase
    end

    always_ff @(posedge i_w_clk) begin
        if (!i_w_reset) begin
            cp  <= '0;
            ri  <= '0;
            ind <= '0;
        end else begin
            if (ctrl.cp_we)  cp  <= bus;
            if (ctrl.ri_we)  ri  <= instr_t'(bus);
            if (ctrl.ind_we) ind <= alu_flags;
        end
    end

    always_ff @(posedge i_w_clk) begin
        if (ctrl.t1_we) t1 <= bus;
        if (ctrl.t2_we) t2 <= bus;
        if (ctrl.am_we) am <= bus[PROG_AW-1:0];   // upper cp bits unused
    end

    assign ctrl.ri  = ri;
    assign ctrl.ind = ind;

    assign o_reg_we     = ctrl.regs_we;
    assign o_reg_addr   = ctrl.regs_addr;
    assign o_reg_data   = bus;
    assign o_instr_done = ctrl.instr_done;
    assign o_pc         = cp;              // not yet incremented in INC_CP1
    assign o_flags      = ind;

    a_cp_from_alu: assert property (@(posedge i_w_clk) disable iff (!i_w_reset)
        ctrl.cp_we |-> ctrl.bus_src == BUS_ALU);

endmodule

//--- rtl/cpu_top.sv
module cpu_top (
    input  logic                        i_w_clk,
    input  logic                        i_w_reset,
    input  logic                        i_prog_we,
    input  logic [cpu_pkg::PROG_AW-1:0] i_prog_addr,
    input  logic [cpu_pkg::DATA_W-1:0]  i_prog_data,
    input  logic                        i_start,
    output logic                        o_busy,
    output logic                        o_reg_we,
    output logic [cpu_pkg::REG_AW-1:0]  o_reg_addr,
    output logic [cpu_pkg::DATA_W-1:0]  o_reg_data,
    output logic                        o_instr_done,
    output logic [cpu_pkg::DATA_W-1:0]  o_pc,
    output cpu_pkg::flags_t             o_flags
);

    cpu_ctrl_if ctrl_if ();     // control word, sequencer to datapath

    cpu_sequencer u_seq (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_start   (i_start),
        .ctrl      (ctrl_if.seq),
        .o_busy    (o_busy)
    );

    cpu_datapath u_dp (
        .i_w_clk      (i_w_clk),
        .i_w_reset    (i_w_reset),
        .ctrl         (ctrl_if.dp),
        .i_prog_we    (i_prog_we),
        .i_prog_addr  (i_prog_addr),
        .i_prog_data  (i_prog_data),
        .o_reg_we     (o_reg_we),
        .o_reg_addr   (o_reg_addr),
        .o_reg_data   (o_reg_data),
        .o_instr_done (o_instr_done),
        .o_pc         (o_pc),
        .o_flags      (o_flags)
    );

endmodule

//--- test/cpu_checker.sv
module cpu_checker (
    input  logic                        i_w_clk,
    input  logic                        i_w_reset,
    input  logic                        i_prog_we,
    input  logic [cpu_pkg::PROG_AW-1:0] i_prog_addr,
    input  logic [cpu_pkg::DATA_W-1:0]  i_prog_data,
    input  logic                        i_start,
    input  logic                        i_busy,
    input  logic                        i_reg_we,
    input  logic [cpu_pkg::REG_AW-1:0]  i_reg_addr,
    input  logic [cpu_pkg::DATA_W-1:0]  i_reg_data,
    input  logic                        i_instr_done,
    input  logic [cpu_pkg::DATA_W-1:0]  i_pc,
    input  cpu_pkg::flags_t             i_flags,
    input  int                          i_num_instr,
    output int                          o_errors,
    output logic                        o_finished
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int INSTR_TIMEOUT = 100;
    localparam int START_TIMEOUT = 2000;

    logic [DATA_W-1:0] model_mem [PROG_DEPTH];     // copy of the loaded program
    logic [DATA_W-1:0] model_regs [NUM_REGS];
    flags_t            model_flags;
    logic [DATA_W-1:0] model_pc;

    always @(posedge i_w_clk) begin
        if (i_prog_we) model_mem[i_prog_addr] <= i_prog_data;
    end

    task automatic compare_field(input string name, input logic [15:0] exp_val,
                                 input logic [15:0] act_val);
        if (exp_val !== act_val) begin
            $display("Fail %s expected %h got %h at pc %0d", name, exp_val, act_val,
                     model_pc);
            o_errors++;
        end
    endtask

    // reference result and flags from the instruction rules
    task automatic model_alu(input logic one_op, input logic [2:0] op,
                             input logic [15:0] a, input logic [15:0] b,
                             input logic cin, output logic [15:0] res,
                             output flags_t f);
        int s;
        logic c;
        if (one_op) begin
            case (op)
                3'd0:    s = int'(a) + 1;            // INC
                3'd1:    s = int'(a) - 1;            // DEC
                3'd2:    s = 0 - int'(a);            // NEG
                3'd3:    s = int'(a ^ 16'hffff);     // NOT
                3'd4:    s = int'(a) * 2;            // SHL puts the msb above bit 15
                3'd5:    s = int'(a >> 1);
                default: s = int'({a[15], a[15:1]}); // SAR
            endcase
        end else begin
            case (op)
                3'd0:    s = int'(a) + int'(b);
                3'd1:    s = int'(a) + int'(b) + int'(cin);
                3'd2:    s = int'(a) - int'(b);
                3'd3:    s = int'(a) - int'(b) - int'(cin);
                3'd4:    s = int'(a & b);
                3'd5:    s = int'(a | b);
                default: s = int'(a ^ b);
            endcase
        end
        c = (s < 0) || (s > 65535);
        if (one_op && (op == 3'd5 || op == 3'd6)) c = a[0];   // right shifts
        res     = s[15:0];
        f.carry = c;
        f.zero  = (res == 16'h0000);
        f.sign  = res[15];
    endtask

    task automatic check_one_instr(output logic timed_out);
        instr_t      ins;
        logic [2:0]  op;
        logic        is_one;
        logic        is_two;
        logic        exp_we;
        logic [2:0]  dst;
        logic [2:0]  src;
        logic [15:0] res;
        flags_t      nf;
        logic        seen_we;
        logic        done;
        int          cyc;
        ins    = instr_t'(model_mem[model_pc[PROG_AW-1:0]]);
        op     = ins.cop[2:0];
        is_one = (ins.mod == 2'b11) && (op != 3'b111) && (ins.cop[6:3] == 4'b0001);
        is_two = (ins.mod == 2'b11) && (op != 3'b111) && (ins.cop[6:4] == 3'b010);
        exp_we = is_one || (is_two && ins.cop[3]);
        dst    = (is_two && ins.d) ? ins.rg : ins.rm;
        src    = ins.d ? ins.rm : ins.rg;
        model_alu(is_one, op, model_regs[dst], model_regs[src], model_flags.carry, res, nf);
        if (!(is_one || is_two)) nf = model_flags;        // no-op keeps flags
        seen_we   = 1'b0;
        done      = 1'b0;
        cyc       = 0;
        timed_out = 1'b0;
        while (!done && cyc < INSTR_TIMEOUT) begin
            @(negedge i_w_clk);
            cyc++;
            if (!i_busy) begin
                $display("o_busy dropped while the program was running");
                o_errors++;
            end
            if (i_reg_we) begin
                if (!exp_we || seen_we) begin
                    $display("unexpected register write at pc %0d", model_pc);
                    o_errors++;
                end else begin
                    compare_field("o_reg_addr", 16'(dst), 16'(i_reg_addr));
                    compare_field("o_reg_data", res, i_reg_data);
                end
                seen_we = 1'b1;
            end
            if (i_instr_done) begin
                done = 1'b1;
                compare_field("o_pc", model_pc, i_pc);
                compare_field("o_flags", 16'(nf), 16'(i_flags));
            end
        end
        if (!done) begin
            $display("instruction at pc %0d never completed", model_pc);
            o_errors++;
            timed_out = 1'b1;
        end else begin
            if (exp_we && !seen_we) begin
                $display("register write missing for instruction at pc %0d", model_pc);
                o_errors++;
            end
            if (exp_we) model_regs[dst] = res;
            model_flags = nf;
            model_pc    = model_pc + 16'd1;
        end
    endtask

    initial begin : run_model
        int   cyc;
        logic seen_start;
        logic stuck;
        o_errors    = 0;
        o_finished  = 1'b0;
        model_flags = '0;
        model_pc    = '0;
        seen_start  = 1'b0;
        stuck       = 1'b0;
        cyc         = 0;
        for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
        // outputs must stay quiet until the start strobe
        while (!seen_start && cyc < START_TIMEOUT) begin
            @(negedge i_w_clk);
            cyc++;
            if (i_w_reset) begin
                if (i_busy || i_reg_we || i_instr_done) begin
                    $display("outputs active before the start strobe");
                    o_errors++;
                end
                if (i_start) seen_start = 1'b1;
            end
        end
        if (!seen_start) begin
            $display("start strobe never arrived");
            o_errors++;
        end else begin
            for (int k = 0; k < i_num_instr && !stuck; k++) check_one_instr(stuck);
        end
        o_finished = 1'b1;
    end

endmodule

//--- test/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int PROG_LEN    = 200;
    localparam int PROLOGUE    = 16;                   // INC chain over all registers
    localparam int RUN_TIMEOUT = PROG_LEN * 100 + 1000;

    logic               w_clk;
    logic               w_reset;
    logic               prog_we;
    logic [PROG_AW-1:0] prog_addr;
    logic [DATA_W-1:0]  prog_data;
    logic               start;
    logic               busy;
    logic               reg_we;
    logic [REG_AW-1:0]  reg_addr;
    logic [DATA_W-1:0]  reg_data;
    logic               instr_done;
    logic [DATA_W-1:0]  pc;
    flags_t             flags;
    int                 chk_errors;
    logic               chk_finished;
    logic [DATA_W-1:0]  prog [PROG_LEN];

    cpu_top i_dut (
        .i_w_clk      (w_clk),
        .i_w_reset    (w_reset),
        .i_prog_we    (prog_we),
        .i_prog_addr  (prog_addr),
        .i_prog_data  (prog_data),
        .i_start      (start),
        .o_busy       (busy),
        .o_reg_we     (reg_we),
        .o_reg_addr   (reg_addr),
        .o_reg_data   (reg_data),
        .o_instr_done (instr_done),
        .o_pc         (pc),
        .o_flags      (flags)
    );

    cpu_checker u_checker (
        .i_w_clk      (w_clk),
        .i_w_reset    (w_reset),
        .i_prog_we    (prog_we),
        .i_prog_addr  (prog_addr),
        .i_prog_data  (prog_data),
        .i_start      (start),
        .i_busy       (busy),
        .i_reg_we     (reg_we),
        .i_reg_addr   (reg_addr),
        .i_reg_data   (reg_data),
        .i_instr_done (instr_done),
        .i_pc         (pc),
        .i_flags      (flags),
        .i_num_instr  (PROG_LEN),
        .o_errors     (chk_errors),
        .o_finished   (chk_finished)
    );

    // register-mode ALU instruction with random op, direction and store bit
    function automatic logic [15:0] random_alu_instr();
        logic [2:0] op;
        logic [6:0] cop;
        op = 3'($urandom_range(6));
        if ($urandom_range(1) == 0) cop = {4'b0001, op};
        else cop = {3'b010, 1'($urandom_range(1)), op};
        return {cop, 1'($urandom_range(1)), 2'b11, 3'($urandom_range(7)),
                3'($urandom_range(7))};
    endfunction

    initial begin
        w_clk = 1'b0;
        forever #10 w_clk = ~w_clk;
    end

    initial begin
        int cyc;
        void'($urandom(32'hf4ee));
        w_reset   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i < PROLOGUE) prog[i] = {7'b0001000, 1'b0, 2'b11, 3'd0, 3'(i % 8)};
            else if ($urandom_range(99) < 70) prog[i] = random_alu_instr();
            else prog[i] = 16'($urandom);                 // mostly no-ops
        end
        repeat (8) @(posedge w_clk);
        #2 w_reset = 1'b1;
        repeat (4) @(posedge w_clk);
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge w_clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = PROG_AW'(i);
            prog_data = prog[i];
        end
        @(posedge w_clk);
        #2 prog_we = 1'b0;
        repeat (3) @(posedge w_clk);
        #2 start = 1'b1;
        @(posedge w_clk);
        #2 start = 1'b0;
        cyc = 0;
        while (!chk_finished && cyc < RUN_TIMEOUT) begin
            @(posedge w_clk);
            cyc++;
        end
        if (!chk_finished) $display("run timed out before the checker finished");
        $display("checked %0d instructions, %0d errors", PROG_LEN, chk_errors);
        if (chk_finished && chk_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/cpu_pkg.sv
rtl/cpu_ctrl_if.sv
rtl/cpu_alu.sv
rtl/cpu_regfile.sv
rtl/cpu_prog_mem.sv
rtl/cpu_sequencer.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/cpu_ctrl_if.sv
      - rtl/cpu_alu.sv
      - rtl/cpu_regfile.sv
      - rtl/cpu_prog_mem.sv
      - rtl/cpu_sequencer.sv
      - rtl/cpu_datapath.sv
      - rtl/cpu_top.sv
  - target: test
    files:
      - test/cpu_checker.sv
      - test/cpu_tb.sv
